// ==== source/core_pkg.sv ====
`default_nettype none

package core_pkg;

	localparam int XLEN    = 32;
	localparam int NREGS   = 32;
	localparam int REG_AW  = $clog2(NREGS);
	localparam int SHAMT_W = $clog2(XLEN);

	// accepted major opcodes
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;

	// funct3 codes shared by OP and OP-IMM
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;	// sub and sra

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B
	} alu_op_t;

	typedef struct packed {
		logic [XLEN-1:0]   pc;
		logic [XLEN-1:0]   rs1_val;
		logic [XLEN-1:0]   rs2_val;
		logic [XLEN-1:0]   imm;
		logic              use_imm;	// operand b from imm
		logic              use_pc;	// operand a from pc
		alu_op_t           alu_op;
		logic [REG_AW-1:0] rd;
		logic              rf_wr;
		logic              illegal;
	} dec_pkt_t;

	typedef struct packed {
		logic [XLEN-1:0]   pc;
		logic [REG_AW-1:0] rd;
		logic [XLEN-1:0]   data;
		logic              rf_wr;
		logic              illegal;
	} ret_pkt_t;

endpackage

`default_nettype wire

// ==== source/reg_file.sv ====
`default_nettype none

module reg_file (
	input  wire logic                        clk,
	input  wire logic                        rst_n,
	input  wire logic [core_pkg::REG_AW-1:0] i_raddr_a,
	input  wire logic [core_pkg::REG_AW-1:0] i_raddr_b,
	input  wire logic                        i_wen,
	input  wire logic [core_pkg::REG_AW-1:0] i_waddr,
	input  wire logic [core_pkg::XLEN-1:0]   i_wdata,
	output logic      [core_pkg::XLEN-1:0]   o_rdata_a,
	output logic      [core_pkg::XLEN-1:0]   o_rdata_b
);

	import core_pkg::*;

	logic [XLEN-1:0] regs [NREGS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wen && (i_waddr != '0)) begin	// x0 is hardwired
			regs[i_waddr] <= i_wdata;
		end
	end

	// asynchronous read ports
	assign o_rdata_a = (i_raddr_a == '0) ? '0 : regs[i_raddr_a];
	assign o_rdata_b = (i_raddr_b == '0) ? '0 : regs[i_raddr_b];

endmodule

`default_nettype wire

// ==== source/instr_decode.sv ====
`default_nettype none

module instr_decode (
	input  wire logic                        i_instr_valid,
	input  wire logic [core_pkg::XLEN-1:0]   i_instr,
	input  wire logic [core_pkg::XLEN-1:0]   i_pc,
	input  wire logic [core_pkg::XLEN-1:0]   i_rs1_val,
	input  wire logic [core_pkg::XLEN-1:0]   i_rs2_val,
	input  wire logic [core_pkg::REG_AW-1:0] i_ex_rd,
	input  wire logic                        i_ex_busy,
	input  wire logic [core_pkg::REG_AW-1:0] i_wb_rd,
	input  wire logic                        i_wb_busy,
	input  wire logic                        i_next_ready,
	output logic                             o_instr_ready,
	output logic      [core_pkg::REG_AW-1:0] o_rs1,
	output logic      [core_pkg::REG_AW-1:0] o_rs2,
	output logic                             o_valid,
	output core_pkg::dec_pkt_t               o_pkt
);

	import core_pkg::*;

	logic [6:0]        opcode;
	logic [2:0]        funct3;
	logic [6:0]        funct7;
	logic [XLEN-1:0]   imm_i;
	logic [XLEN-1:0]   imm_u;
	logic [XLEN-1:0]   imm;
	logic              use_imm;
	logic              use_pc;
	logic              use_rs1;
	logic              use_rs2;
	logic              illegal;
	alu_op_t           alu_op;
	logic              hazard;

	// map funct3 to an alu op before funct7 refines it
	function automatic alu_op_t base_op(input logic [2:0] f3);
		case (f3)
			F3_ADD:  return ALU_ADD;
			F3_SLL:  return ALU_SLL;
			F3_SLT:  return ALU_SLT;
			F3_SLTU: return ALU_SLTU;
			F3_XOR:  return ALU_XOR;
			F3_SR:   return ALU_SRL;
			F3_OR:   return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	// source register busy in either stage register
	function automatic logic busy_match(input logic [REG_AW-1:0] src);
		return (src != '0) &&
			((i_ex_busy && (src == i_ex_rd)) || (i_wb_busy && (src == i_wb_rd)));
	endfunction

	assign opcode = i_instr[6:0];
	assign funct3 = i_instr[14:12];
	assign funct7 = i_instr[31:25];
	assign o_rs1  = i_instr[19:15];
	assign o_rs2  = i_instr[24:20];

	assign imm_i = {{(XLEN-12){i_instr[31]}}, i_instr[31:20]};	// sign extended
	assign imm_u = {i_instr[31:12], 12'b0};

	always_comb begin
		alu_op  = ALU_ADD;
		imm     = imm_i;
		use_imm = 1'b0;
		use_pc  = 1'b0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		illegal = 1'b0;
		case (opcode)
			OPC_LUI: begin
				alu_op  = ALU_PASS_B;	// imm straight through
				imm     = imm_u;
				use_imm = 1'b1;
			end
			OPC_AUIPC: begin
				imm     = imm_u;
				use_imm = 1'b1;
				use_pc  = 1'b1;
			end
			OPC_OP_IMM: begin
				use_imm = 1'b1;
				use_rs1 = 1'b1;
				alu_op  = base_op(funct3);
				if (funct3 == F3_SLL) begin
					illegal = (funct7 != F7_BASE);
				end else if (funct3 == F3_SR) begin
					if (funct7 == F7_ALT) begin
						alu_op = ALU_SRA;
					end else begin
						illegal = (funct7 != F7_BASE);
					end
				end
			end
			OPC_OP: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				alu_op  = base_op(funct3);
				if ((funct7 == F7_ALT) && (funct3 == F3_ADD)) begin
					alu_op = ALU_SUB;
				end else if ((funct7 == F7_ALT) && (funct3 == F3_SR)) begin
					alu_op = ALU_SRA;
				end else begin
					illegal = (funct7 != F7_BASE);
				end
			end
			default: illegal = 1'b1;	// unknown opcode
		endcase
	end

	// hold the instruction until its sources have left the pipe
	assign hazard = (use_rs1 && busy_match(o_rs1)) || (use_rs2 && busy_match(o_rs2));

	assign o_valid       = i_instr_valid && !hazard;
	assign o_instr_ready = i_next_ready && !(i_instr_valid && hazard);

	assign o_pkt = '{
		pc:      i_pc,
		rs1_val: i_rs1_val,
		rs2_val: i_rs2_val,
		imm:     imm,
		use_imm: use_imm,
		use_pc:  use_pc,
		alu_op:  alu_op,
		rd:      i_instr[11:7],
		rf_wr:   !illegal,
		illegal: illegal
	};

endmodule

`default_nettype wire

// ==== source/stage_reg.sv ====
`default_nettype none

module stage_reg #(
	parameter type t_payload = logic
) (
	input  wire logic     clk,
	input  wire logic     rst_n,
	input  wire logic     i_valid,
	input  wire t_payload i_data,
	output logic          o_ready,
	output logic          o_valid,
	output t_payload      o_data,
	input  wire logic     i_ready
);

	logic load;

	// empty or draining this cycle
	assign o_ready = !o_valid || i_ready;
	assign load    = i_valid && o_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_valid <= 1'b0;
		end else if (o_ready) begin
			o_valid <= i_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			o_data <= i_data;
		end
	end

endmodule

`default_nettype wire

// ==== source/int_alu.sv ====
`default_nettype none

module int_alu (
	input  wire core_pkg::dec_pkt_t i_pkt,
	output core_pkg::ret_pkt_t      o_pkt
);

	import core_pkg::*;

	logic [XLEN-1:0]    op_a;
	logic [XLEN-1:0]    op_b;
	logic [SHAMT_W-1:0] shamt;
	logic [XLEN-1:0]    result;

	assign op_a  = i_pkt.use_pc ? i_pkt.pc : i_pkt.rs1_val;
	assign op_b  = i_pkt.use_imm ? i_pkt.imm : i_pkt.rs2_val;
	assign shamt = op_b[SHAMT_W-1:0];

	always_comb begin
		case (i_pkt.alu_op)
			ALU_ADD:    result = op_a + op_b;
			ALU_SUB:    result = op_a - op_b;
			ALU_SLL:    result = op_a << shamt;
			ALU_SLT:    result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			ALU_SLTU:   result = {{(XLEN-1){1'b0}}, op_a < op_b};
			ALU_XOR:    result = op_a ^ op_b;
			ALU_SRL:    result = op_a >> shamt;
			ALU_SRA:    result = $signed(op_a) >>> shamt;	// keeps the sign
			ALU_OR:     result = op_a | op_b;
			ALU_AND:    result = op_a & op_b;
			ALU_PASS_B: result = op_b;
			default:    result = '0;
		endcase
	end

	assign o_pkt = '{
		pc:      i_pkt.pc,
		rd:      i_pkt.rd,
		data:    i_pkt.illegal ? '0 : result,	// zero for illegal
		rf_wr:   i_pkt.rf_wr,
		illegal: i_pkt.illegal
	};

endmodule

`default_nettype wire

// ==== source/retire_unit.sv ====
`default_nettype none

module retire_unit (
	input  wire logic                        i_valid,
	input  wire core_pkg::ret_pkt_t          i_pkt,
	output logic                             o_ready,
	output logic                             o_ret_valid,
	output core_pkg::ret_pkt_t               o_ret,
	input  wire logic                        i_ret_ready,
	output logic                             o_rf_wen,
	output logic      [core_pkg::REG_AW-1:0] o_rf_waddr,
	output logic      [core_pkg::XLEN-1:0]   o_rf_wdata
);

	logic ret_xfer;

	assign o_ret_valid = i_valid;
	assign o_ret       = i_pkt;
	assign o_ready     = i_ret_ready;

	// write back only when the record actually leaves
	assign ret_xfer   = i_valid && i_ret_ready;
	assign o_rf_wen   = ret_xfer && i_pkt.rf_wr && (i_pkt.rd != '0);
	assign o_rf_waddr = i_pkt.rd;
	assign o_rf_wdata = i_pkt.data;

endmodule

`default_nettype wire

// ==== source/int_pipe_core.sv ====
`default_nettype none

module int_pipe_core (
	input  wire logic                      clk,
	input  wire logic                      rst_n,
	input  wire logic                      i_instr_valid,
	input  wire logic [core_pkg::XLEN-1:0] i_instr,
	input  wire logic [core_pkg::XLEN-1:0] i_pc,
	output logic                           o_instr_ready,
	output logic                           o_ret_valid,
	output core_pkg::ret_pkt_t             o_ret,
	input  wire logic                      i_ret_ready
);

	import core_pkg::*;

	logic [REG_AW-1:0] rs1_addr;
	logic [REG_AW-1:0] rs2_addr;
	logic [XLEN-1:0]   rs1_val;
	logic [XLEN-1:0]   rs2_val;
	logic              rf_wen;
	logic [REG_AW-1:0] rf_waddr;
	logic [XLEN-1:0]   rf_wdata;

	logic              dec_valid;
	dec_pkt_t          dec_pkt;
	logic              ex_ready;
	logic              ex_valid;
	dec_pkt_t          ex_pkt;
	ret_pkt_t          alu_pkt;
	logic              wb_ready;
	logic              wb_valid;
	ret_pkt_t          wb_pkt;
	logic              ret_ready;

	reg_file reg_file_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_raddr_a (rs1_addr),
		.i_raddr_b (rs2_addr),
		.i_wen     (rf_wen),
		.i_waddr   (rf_waddr),
		.i_wdata   (rf_wdata),
		.o_rdata_a (rs1_val),
		.o_rdata_b (rs2_val)
	);

	instr_decode instr_decode_inst (
		.i_instr_valid (i_instr_valid),
		.i_instr       (i_instr),
		.i_pc          (i_pc),
		.i_rs1_val     (rs1_val),
		.i_rs2_val     (rs2_val),
		.i_ex_rd       (ex_pkt.rd),
		.i_ex_busy     (ex_valid && ex_pkt.rf_wr),	// pending writes only
		.i_wb_rd       (wb_pkt.rd),
		.i_wb_busy     (wb_valid && wb_pkt.rf_wr),
		.i_next_ready  (ex_ready),
		.o_instr_ready (o_instr_ready),
		.o_rs1         (rs1_addr),
		.o_rs2         (rs2_addr),
		.o_valid       (dec_valid),
		.o_pkt         (dec_pkt)
	);

	// decode to execute
	stage_reg #(.t_payload(dec_pkt_t)) dec_ex_reg (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_valid (dec_valid),
		.i_data  (dec_pkt),
		.o_ready (ex_ready),
		.o_valid (ex_valid),
		.o_data  (ex_pkt),
		.i_ready (wb_ready)
	);

	int_alu int_alu_inst (
		.i_pkt (ex_pkt),
		.o_pkt (alu_pkt)
	);

	// execute to result
	stage_reg #(.t_payload(ret_pkt_t)) ex_wb_reg (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_valid (ex_valid),
		.i_data  (alu_pkt),
		.o_ready (wb_ready),
		.o_valid (wb_valid),
		.o_data  (wb_pkt),
		.i_ready (ret_ready)
	);

	retire_unit retire_unit_inst (
		.i_valid     (wb_valid),
		.i_pkt       (wb_pkt),
		.o_ready     (ret_ready),
		.o_ret_valid (o_ret_valid),
		.o_ret       (o_ret),
		.i_ret_ready (i_ret_ready),
		.o_rf_wen    (rf_wen),
		.o_rf_waddr  (rf_waddr),
		.o_rf_wdata  (rf_wdata)
	);

endmodule

`default_nettype wire

// ==== tb/core_props.sv ====
`default_nettype none

module core_props (
	input wire logic               clk,
	input wire logic               rst_n,
	input wire logic               o_ret_valid,
	input wire logic               i_ret_ready,
	input wire core_pkg::ret_pkt_t o_ret
);

	int prop_fails = 0;	// read by the testbench

	// a stalled record must not move
	assert property (@(posedge clk) disable iff (!rst_n)
		(o_ret_valid && !i_ret_ready) |=> (o_ret_valid && $stable(o_ret)))
	else begin
		$error("retire record changed or dropped while stalled");
		prop_fails++;
	end

	assert property (@(posedge clk) $rose(rst_n) |-> !o_ret_valid)
	else begin
		$error("retire valid high right after reset release");
		prop_fails++;
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		o_ret_valid |-> !(o_ret.rf_wr && o_ret.illegal))
	else begin
		$error("retire record shows a register write on an illegal instruction");
		prop_fails++;
	end

endmodule

bind int_pipe_core core_props core_props_inst (
	.clk         (clk),
	.rst_n       (rst_n),
	.o_ret_valid (o_ret_valid),
	.i_ret_ready (i_ret_ready),
	.o_ret       (o_ret)
);

`default_nettype wire

// ==== tb/core_tb.sv ====
`default_nettype none

module core_tb;

	import core_pkg::*;

	logic            clk;
	logic            rst_n;
	logic            i_instr_valid;
	logic [XLEN-1:0] i_instr;
	logic [XLEN-1:0] i_pc;
	logic            o_instr_ready;
	logic            o_ret_valid;
	ret_pkt_t        o_ret;
	logic            i_ret_ready;

	integer          seed;
	int              n_cases;
	int              retired;
	int              cycles;
	int              limit;
	int              value_errors;
	int              other_errors;
	logic [XLEN-1:0] case_pc [$];
	logic [XLEN-1:0] case_instr [$];
	ret_pkt_t        exp_q [$];
	ret_pkt_t        want;

	int_pipe_core int_pipe_core_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_instr_valid (i_instr_valid),
		.i_instr       (i_instr),
		.i_pc          (i_pc),
		.o_instr_ready (o_instr_ready),
		.o_ret_valid   (o_ret_valid),
		.o_ret         (o_ret),
		.i_ret_ready   (i_ret_ready)
	);

	always #20 clk = ~clk;

	task automatic compare_field(input string name, input logic [XLEN-1:0] exp,
			input logic [XLEN-1:0] act);
		assert (act === exp) else begin
			value_errors++;
			$display("error at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	// case file columns are pc instr rd data rf_wr illegal in hex
	task automatic read_cases();
		int              fd;
		int              n;
		string           line;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] instr;
		logic [XLEN-1:0] rd;
		logic [XLEN-1:0] data;
		logic [XLEN-1:0] wr;
		logic [XLEN-1:0] ill;
		fd = $fopen("tb/core_cases.txt", "r");
		assert (fd != 0) else begin
			other_errors++;
			$display("could not open the case file tb/core_cases.txt");
		end
		if (fd != 0) begin
			while (!$feof(fd)) begin
				if ($fgets(line, fd) == 0) break;
				if (line.substr(0, 0) == "#") continue;	// column notes
				n = $sscanf(line, "%h %h %h %h %h %h", pc, instr, rd, data, wr, ill);
				if (n != 6) continue;
				case_pc.push_back(pc);
				case_instr.push_back(instr);
				exp_q.push_back('{pc: pc, rd: rd[REG_AW-1:0], data: data,
					rf_wr: wr[0], illegal: ill[0]});
			end
			$fclose(fd);
		end
		n_cases = case_pc.size();
	endtask

	task automatic print_summary();
		$display("errors: %0d value, %0d other, %0d assertion; %0d of %0d cases retired",
			value_errors, other_errors, int_pipe_core_inst.core_props_inst.prop_fails,
			retired, n_cases);
	endtask

	// random back-pressure on the retire port
	always @(posedge clk) begin
		if (rst_n) begin
			i_ret_ready <= (($random(seed) & 3) != 0);
		end
	end

	// sample the retire port at the falling edge
	always @(negedge clk) begin
		if (rst_n && o_ret_valid && i_ret_ready) begin
			assert (exp_q.size() > 0) else begin
				other_errors++;
				$display("unexpected retire record at %0t", $time);
			end
			if (exp_q.size() > 0) begin
				want = exp_q.pop_front();
				compare_field("o_ret.pc", want.pc, o_ret.pc);
				compare_field("o_ret.rd", want.rd, o_ret.rd);
				compare_field("o_ret.data", want.data, o_ret.data);
				compare_field("o_ret.rf_wr", want.rf_wr, o_ret.rf_wr);
				compare_field("o_ret.illegal", want.illegal, o_ret.illegal);
			end
			retired++;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("timeout after %0d cycles with %0d of %0d records retired",
				cycles, retired, n_cases);
			print_summary();
			$display("TESTS FAILED");
			$finish;
		end
	end

	initial begin
		clk           = 1'b0;
		rst_n         = 1'b0;
		i_instr_valid = 1'b0;
		i_instr       = '0;
		i_pc          = '0;
		i_ret_ready   = 1'b0;
		seed          = 32'ha01d;
		retired       = 0;
		cycles        = 0;
		value_errors  = 0;
		other_errors  = 0;
		limit         = 1000;
		read_cases();
		limit = 40 * n_cases + 100;

		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		compare_field("o_ret_valid", '0, {31'd0, o_ret_valid});
		compare_field("o_instr_ready", 32'd1, {31'd0, o_instr_ready});

		@(posedge clk);
		for (int i = 0; i < n_cases; i++) begin
			if (($random(seed) & 3) == 0) begin	// idle gap
				i_instr_valid <= 1'b0;
				@(posedge clk);
			end
			i_instr_valid <= 1'b1;
			i_instr       <= case_instr[i];
			i_pc          <= case_pc[i];
			do @(negedge clk); while (!o_instr_ready);
			@(posedge clk);	// transfer edge
		end
		i_instr_valid <= 1'b0;

		wait (retired == n_cases);
		repeat (5) @(posedge clk);	// catch extra records
		assert ((n_cases > 0) && (retired == n_cases)) else begin
			other_errors++;
			$display("retired %0d records for %0d cases", retired, n_cases);
		end

		print_summary();
		if ((value_errors + other_errors == 0) &&
				(int_pipe_core_inst.core_props_inst.prop_fails == 0)) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/core_pkg.sv
source/reg_file.sv
source/instr_decode.sv
source/stage_reg.sv
source/int_alu.sv
source/retire_unit.sv
source/int_pipe_core.sv
tb/core_props.sv
tb/core_tb.sv

// ==== tb/core_cases.txt ====
# pc instr rd data rf_wr illegal, all hex
# registers start at zero, expected data follows RV32I results
00000100 123450B7 01 12345000 1 0
00000104 67808093 01 12345678 1 0
00000108 00001117 02 00001108 1 0
0000010C 002081B3 03 12346780 1 0
00000110 40118233 04 00001108 1 0
00000114 FFF00293 05 FFFFFFFF 1 0
00000118 4042D313 06 FFFFFFFF 1 0
0000011C 0042D393 07 0FFFFFFF 1 0
00000120 00809413 08 34567800 1 0
00000124 0002A493 09 00000001 1 0
00000128 0012B513 0A 00000000 1 0
0000012C 0FF0C593 0B 12345687 1 0
00000130 55506613 0C 00000555 1 0
00000134 FF00F693 0D 12345670 1 0
00000138 00909733 0E 2468ACF0 1 0
0000013C 0012A7B3 0F 00000001 1 0
00000140 0012B833 10 00000000 1 0
00000144 00C0C8B3 11 1234532D 1 0
00000148 0092D933 12 7FFFFFFF 1 0
0000014C 4092D9B3 13 FFFFFFFF 1 0
00000150 00966A33 14 00000555 1 0
00000154 0050FAB3 15 12345678 1 0
00000158 000001FF 03 00000000 0 1
0000015C 02208233 04 00000000 0 1
00000160 00018B13 16 12346780 1 0
00000164 00020BB3 17 00001108 1 0
00000168 00508013 00 1234567D 1 0
0000016C 00006C33 18 00000000 1 0
00000170 40109C93 19 00000000 0 1
00000174 FFFFFD37 1A FFFFF000 1 0
00000178 7FFD0D13 1A FFFFF7FF 1 0
0000017C 41A00DB3 1B 00000801 1 0
